/* Makefile */
VERILATOR = verilator
VFLAGS = --binary -sv --timing -Wno-fatal
TOP = tb_fpu
FLIST = flist.f
OBJ_DIR = obj_dir
PASS_MSG = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+include
+incdir+tb
source/fpu_pkg.sv
source/fpu_decode_unpack.sv
source/fpu_addsub.sv
source/fpu_mul.sv
source/fpu_result_select.sv
source/fpu_top.sv
tb/tb_fpu.sv

/* include/fpu_settings.svh */
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// single precision field layout
`define FP_EXP_W 8
`define FP_MAN_W 23

`define FP_BIAS 8'd127
`define FP_EXP_MAX 8'd255	// inf and nan exponent

// quiet nan returned by invalid arithmetic
`define FP_QNAN_NEG 32'hffc0_0000

// cop1 instruction fields
`define FPU_OP_COP1 6'b010001
`define FPU_FMT_S 5'b10000

// funct codes for fmt s
`define FPU_FN_ADD 6'd0
`define FPU_FN_SUB 6'd1
`define FPU_FN_MUL 6'd2
`define FPU_FN_ABS 6'd5
`define FPU_FN_NEG 6'd7

`endif

/* source/fpu_addsub.sv */
`default_nettype none
`include "fpu_settings.svh"

module fpu_addsub (
	input wire fpu_pkg::fpu_issue_t issue,
	output fpu_pkg::fpu_arith_t res
);
	import fpu_pkg::*;

	wire fp_unpacked_t a = issue.a;
	wire fp_unpacked_t b = issue.b;

	// sub becomes add of the negated second operand
	wire sb = b.sign ^ (issue.op == op_sub);
	wire eff_add = (a.sign == sb);

	// effective addition
	// w has the larger exponent and l the smaller
	wire a_ge_exp = a.exp >= b.exp;
	wire [7:0] add_ew = a_ge_exp ? a.exp : b.exp;
	wire [7:0] add_el = a_ge_exp ? b.exp : a.exp;
	wire [23:0] add_mw = a_ge_exp ? a.sig : b.sig;
	wire [23:0] add_ml = a_ge_exp ? b.sig : a.sig;

	wire [47:0] add_sh = {add_ml, 24'd0} >> (add_ew - add_el);
	wire [25:0] add_al = {add_sh[47:23], |add_sh[22:0]};	// sig, guard, sticky
	wire [26:0] add_sum = {1'b0, add_mw, 2'b00} + {1'b0, add_al};

	// carry out of the hidden bit happens only for normal sums
	wire [26:0] add_c = add_sum[26] ? {1'b0, add_sum[26:2], |add_sum[1:0]} : add_sum;
	wire [8:0] add_e1 = {1'b0, add_ew} + {8'd0, add_sum[26]};

	// round to nearest even
	wire [24:0] add_r = add_c[26:2] + {24'd0, add_c[1] & (add_c[2] | add_c[0])};
	wire [8:0] add_e2 = add_e1 + {8'd0, add_r[24]};
	wire [23:0] add_m = add_r[24] ? 24'h80_0000 : add_r[23:0];
	wire add_ovf = add_e2 >= {1'b0, `FP_EXP_MAX};

	wire [7:0] add_ey = add_ovf ? `FP_EXP_MAX : add_m[23] ? add_e2[7:0] : 8'd0;
	wire [22:0] add_my = add_ovf ? 23'd0 : add_m[22:0];
	wire fp32_t add_y = {a.sign, add_ey, add_my};

	// effective subtraction ordered by magnitude
	wire [30:0] a_mag = {a.raw.exp, a.raw.man};
	wire [30:0] b_mag = {b.raw.exp, b.raw.man};
	wire a_ge_mag = a_mag >= b_mag;
	wire sub_sign = (a_mag > b_mag) ? a.sign : (a_mag == b_mag) ? 1'b0 : sb;	// x - x is +0
	wire [7:0] sub_ew = a_ge_mag ? a.exp : b.exp;
	wire [7:0] sub_el = a_ge_mag ? b.exp : a.exp;
	wire [23:0] sub_mw = a_ge_mag ? a.sig : b.sig;
	wire [23:0] sub_ml = a_ge_mag ? b.sig : a.sig;

	wire [48:0] sub_sh = {sub_ml, 25'd0} >> (sub_ew - sub_el);
	wire [26:0] sub_al = {sub_sh[48:23], |sub_sh[22:0]};	// sig, guard, round, sticky
	wire [26:0] sub_diff = {sub_mw, 3'd0} - sub_al;

	// renormalize no lower than exponent 1
	wire [5:0] sub_lz = count_leading_zeros({sub_diff, 21'd0});
	wire [7:0] sub_lz8 = {2'b00, sub_lz};
	wire lz_fits = sub_lz8 < sub_ew;
	wire [26:0] sub_n = lz_fits ? sub_diff << sub_lz :
		(sub_ew > 8'd1) ? sub_diff << (sub_ew - 8'd1) :	// normal turns denormal
		sub_diff;
	wire [7:0] sub_e1 = lz_fits ? sub_ew - sub_lz8 : 8'd1;

	wire sub_rnd = sub_n[2] & (sub_n[3] | sub_n[1] | sub_n[0]);
	wire [24:0] sub_r = {1'b0, sub_n[26:3]} + {24'd0, sub_rnd};
	wire [7:0] sub_e2 = sub_e1 + {7'd0, sub_r[24]};
	wire [23:0] sub_m = sub_r[24] ? 24'h80_0000 : sub_r[23:0];
	wire fp32_t sub_y = {sub_sign, sub_m[23] ? sub_e2 : 8'd0, sub_m[22:0]};

	// special values
	wire fp32_t a_quiet = {a.raw.sign, a.raw.exp, 1'b1, a.raw.man[21:0]};
	wire fp32_t b_quiet = {b.raw.sign, b.raw.exp, 1'b1, b.raw.man[21:0]};
	wire finite = !a.is_inf && !a.is_nan && !b.is_inf && !b.is_nan;

	always_comb begin
		res.ovf = eff_add && finite && add_ovf;	// subtraction never overflows
		if (b.is_nan && (a.is_nan || a.is_inf))
			res.val = b_quiet;
		else if (a.is_nan)
			res.val = a_quiet;
		else if (b.is_nan)
			res.val = b_quiet;
		else if (a.is_inf && b.is_inf)
			res.val = eff_add ? a.raw : `FP_QNAN_NEG;	// inf - inf
		else if (a.is_inf)
			res.val = a.raw;
		else if (b.is_inf)
			res.val = {sb, `FP_EXP_MAX, 23'd0};
		else if (eff_add)
			res.val = add_y;
		else
			res.val = sub_y;
	end

endmodule

`default_nettype wire

/* source/fpu_decode_unpack.sv */
`default_nettype none
`include "fpu_settings.svh"

module fpu_decode_unpack (
	input wire clk,
	input wire rst_n,
	input wire [5:0] op1,	// instr[31:26]
	input wire [4:0] fmt,	// instr[25:21]
	input wire [5:0] funct,	// instr[5:0]
	input wire fpu_pkg::fp32_t x1,	// fs
	input wire fpu_pkg::fp32_t x2,	// ft
	output fpu_pkg::fpu_issue_t issue
);
	import fpu_pkg::*;

	fpu_op_e op_dec;
	fp_unpacked_t a_dec;
	fp_unpacked_t b_dec;

	function automatic fp_unpacked_t unpack(input fp32_t x);
		fp_unpacked_t u;
		logic dn;
		dn = (x.exp == 8'd0);
		u.sign = x.sign;
		u.exp = dn ? 8'd1 : x.exp;	// denormal exponent is -126 like exp 1
		u.sig = {~dn, x.man};
		u.is_zero = dn && (x.man == '0);
		u.is_inf = (x.exp == `FP_EXP_MAX) && (x.man == '0);
		u.is_nan = (x.exp == `FP_EXP_MAX) && (x.man != '0);
		u.raw = x;
		return u;
	endfunction

	// only single format cop1 ops are kept
	always_comb begin
		op_dec = op_invalid;
		if (op1 == `FPU_OP_COP1 && fmt == `FPU_FMT_S) begin
			case (funct)
				`FPU_FN_ADD: op_dec = op_add;
				`FPU_FN_SUB: op_dec = op_sub;
				`FPU_FN_MUL: op_dec = op_mul;
				`FPU_FN_ABS: op_dec = op_abs;
				`FPU_FN_NEG: op_dec = op_neg;
				default: op_dec = op_invalid;	// div, floor, cvt and the rest
			endcase
		end
	end

	assign a_dec = unpack(x1);
	assign b_dec = unpack(x2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue.op <= op_invalid;
			issue.a <= '0;
			issue.b <= '0;
		end else begin
			issue.op <= op_dec;
			issue.a <= a_dec;
			issue.b <= b_dec;
		end
	end

endmodule

`default_nettype wire

/* source/fpu_mul.sv */
`default_nettype none
`include "fpu_settings.svh"

module fpu_mul (
	input wire fpu_pkg::fpu_issue_t issue,
	output fpu_pkg::fpu_arith_t res
);
	import fpu_pkg::*;

	wire fp_unpacked_t a = issue.a;
	wire fp_unpacked_t b = issue.b;
	wire sy = a.sign ^ b.sign;

	// biased exponent sum is classified before the bias is removed
	wire [8:0] e_sum = {1'b0, a.exp} + {1'b0, b.exp};
	wire dn_always = e_sum < {1'b0, `FP_BIAS};	// result is always denormal
	wire dn_border = e_sum == {1'b0, `FP_BIAS};	// normal only with a carry
	wire [8:0] e_unb = e_sum - {1'b0, `FP_BIAS};

	wire [47:0] prod = {24'd0, a.sig} * {24'd0, b.sig};

	// normal candidate folds a carry into the exponent
	wire [47:0] norm_sh = prod[47] ? {1'b0, prod[47:2], |prod[1:0]} : prod;
	wire [8:0] e_norm = e_unb + {8'd0, prod[47]};

	// denormal candidate shifted right to exponent field 0
	wire [8:0] den_amt = 9'd128 - e_sum;
	wire [95:0] den_wide = {prod, 48'd0} >> den_amt;
	wire [47:0] den_sh = {den_wide[95:49], |den_wide[48:0]};

	wire use_norm = !dn_always && (!dn_border || prod[47]);
	wire [47:0] m2 = use_norm ? norm_sh : den_sh;
	wire [8:0] e3 = use_norm ? e_norm : 9'd0;

	// left normalize when an input was denormal
	wire [8:0] lz = {3'd0, count_leading_zeros({m2[46:0], 1'b0})};
	wire [47:0] m_lz = m2 << lz;
	wire [47:0] m_e3 = m2 << e3;
	wire [47:0] m3 = (lz < e3) ? m_lz :
		use_norm ? m_e3 >> 1 :	// normal range drops to denormal
		m_e3;
	wire [8:0] e4 = (lz <= e3) ? e3 - lz : 9'd0;

	// carry, hidden, mantissa, guard, sticky
	wire [26:0] m4 = {m3[47:22], |m3[21:0]};
	wire [24:0] m5 = m4[26:2] + {24'd0, m4[1] & (m4[2] | m4[0])};

	wire [8:0] e5 = m5[24] ? e4 + 9'd1 :
		(e4 == 9'd0 && m5[23]) ? 9'd1 :	// rounded up into the normal range
		(prod == 48'd0) ? 9'd0 :
		e4;
	wire [22:0] my = m5[24] ? 23'd0 : m5[22:0];
	wire ovf1 = e5 >= {1'b0, `FP_EXP_MAX};

	wire fp32_t a_quiet = {a.raw.sign, a.raw.exp, 1'b1, a.raw.man[21:0]};
	wire fp32_t b_quiet = {b.raw.sign, b.raw.exp, 1'b1, b.raw.man[21:0]};
	wire fp32_t inf_y = {sy, `FP_EXP_MAX, 23'd0};
	wire finite = !a.is_inf && !a.is_nan && !b.is_inf && !b.is_nan;

	always_comb begin
		res.ovf = finite && ovf1;
		if (b.is_nan && (a.is_nan || a.is_inf))
			res.val = b_quiet;
		else if (a.is_nan)
			res.val = a_quiet;
		else if (b.is_nan)
			res.val = b_quiet;
		else if ((a.is_inf && b.is_zero) || (a.is_zero && b.is_inf))
			res.val = `FP_QNAN_NEG;
		else if (a.is_inf || b.is_inf)
			res.val = inf_y;
		else if (ovf1)
			res.val = inf_y;
		else
			res.val = {sy, e5[7:0], my};
	end

endmodule

`default_nettype wire

/* source/fpu_pkg.sv */
`default_nettype none
`include "fpu_settings.svh"

package fpu_pkg;

	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_MAN_W-1:0] man;
	} fp32_t;

	// operand after unpacking
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;	// 1 for a denormal
		logic [`FP_MAN_W:0] sig;	// hidden bit included
		logic is_zero;
		logic is_inf;
		logic is_nan;
		fp32_t raw;	// kept for nan propagation, abs and neg
	} fp_unpacked_t;

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_mul,
		op_abs,
		op_neg,
		op_invalid
	} fpu_op_e;

	typedef struct packed {
		fpu_op_e op;
		fp_unpacked_t a;
		fp_unpacked_t b;
	} fpu_issue_t;

	// 0001 overflow, 1000 invalid op
	typedef struct packed {
		logic invalid;
		logic div0;
		logic nan;
		logic ovf;
	} fpu_exc_t;

	typedef struct packed {
		fp32_t val;
		logic ovf;
	} fpu_arith_t;

	// 48 when v is all zero
	function automatic logic [5:0] count_leading_zeros(input logic [47:0] v);
		logic [5:0] n;
		logic found;
		n = 6'd48;
		found = 1'b0;
		for (int i = 47; i >= 0; i--) begin
			if (v[i] && !found) begin
				n = 6'(47 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

endpackage

`default_nettype wire

/* source/fpu_result_select.sv */
`default_nettype none

module fpu_result_select (
	input wire clk,
	input wire rst_n,
	input wire fpu_pkg::fpu_op_e op,
	input wire fpu_pkg::fp_unpacked_t a,
	input wire fpu_pkg::fpu_arith_t addsub_res,
	input wire fpu_pkg::fpu_arith_t mul_res,
	output fpu_pkg::fp32_t y,
	output fpu_pkg::fpu_exc_t exception
);
	import fpu_pkg::*;

	fp32_t y_nxt;
	fpu_exc_t exc_nxt;

	// abs and neg only touch the sign bit of fs
	wire fp32_t abs_y = {1'b0, a.raw.exp, a.raw.man};
	wire fp32_t neg_y = {~a.raw.sign, a.raw.exp, a.raw.man};

	always_comb begin
		exc_nxt = '0;
		case (op)
			op_add, op_sub: begin
				y_nxt = addsub_res.val;
				exc_nxt.ovf = addsub_res.ovf;
			end
			op_mul: begin
				y_nxt = mul_res.val;
				exc_nxt.ovf = mul_res.ovf;
			end
			op_abs: y_nxt = abs_y;
			op_neg: y_nxt = neg_y;
			default: begin
				y_nxt = '0;
				exc_nxt.invalid = 1'b1;	// code 1000
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			y <= '0;
			exception <= '0;
		end else begin
			y <= y_nxt;
			exception <= exc_nxt;
		end
	end

endmodule

`default_nettype wire

/* source/fpu_top.sv */
`default_nettype none

module fpu_top (
	input wire clk,
	input wire rst_n,
	input wire [5:0] op1,
	input wire [4:0] fmt,
	input wire [5:0] funct,
	input wire fpu_pkg::fp32_t x1,
	input wire fpu_pkg::fp32_t x2,
	output fpu_pkg::fp32_t y,
	output fpu_pkg::fpu_exc_t exception
);
	import fpu_pkg::*;

	fpu_issue_t issue;	// stage 1 register
	fpu_arith_t addsub_res;
	fpu_arith_t mul_res;

	fpu_decode_unpack i_decode (
		.clk(clk),
		.rst_n(rst_n),
		.op1(op1),
		.fmt(fmt),
		.funct(funct),
		.x1(x1),
		.x2(x2),
		.issue(issue)
	);

	fpu_addsub i_addsub (
		.issue(issue),
		.res(addsub_res)
	);

	fpu_mul i_mul (
		.issue(issue),
		.res(mul_res)
	);

	// stage 2 register
	fpu_result_select i_select (
		.clk(clk),
		.rst_n(rst_n),
		.op(issue.op),
		.a(issue.a),
		.addsub_res(addsub_res),
		.mul_res(mul_res),
		.y(y),
		.exception(exception)
	);

endmodule

`default_nettype wire

/* tb/tb_fpu_tasks.svh */
// numerical recipes lcg step
function automatic logic [31:0] next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// integer valued operand below 2^11 in magnitude
function automatic int random_int();
	logic [31:0] r;
	r = next_random();
	return r[31] ? -int'(r[26:16]) : int'(r[26:16]);
endfunction

// exact for magnitudes below 2^24
function automatic fp32_t int_to_fp32(input int v);
	logic [31:0] mag;
	logic [7:0] e;
	mag = (v < 0) ? -v : v;
	e = `FP_BIAS + 8'd31;
	if (mag == 0)
		return '0;
	while (!mag[31]) begin
		mag = mag << 1;
		e = e - 8'd1;
	end
	return {v < 0, e, mag[30:8]};	// hidden bit dropped
endfunction

// expected result of one instruction on integer valued operands
task automatic reference_model(input logic [5:0] fn, input int va, input int vb,
		output fp32_t ye, output fpu_exc_t ee);
	fp32_t fa;
	fa = int_to_fp32(va);
	ee = '0;
	case (fn)
		`FPU_FN_ADD: ye = int_to_fp32(va + vb);	// exact cancellation gives +0
		`FPU_FN_SUB: ye = int_to_fp32(va - vb);
		`FPU_FN_MUL: begin
			ye = int_to_fp32(va * vb);
			ye.sign = (va < 0) ^ (vb < 0);	// a zero product keeps the sign xor
		end
		`FPU_FN_ABS: ye = {1'b0, fa[30:0]};
		`FPU_FN_NEG: ye = {~fa.sign, fa[30:0]};
		default: begin
			ye = '0;
			ee.invalid = 1'b1;
		end
	endcase
endtask

task automatic apply_instr(input logic [5:0] op1_v, input logic [4:0] fmt_v,
		input logic [5:0] funct_v, input fp32_t a, input fp32_t b);
	@(posedge clk);
	#1;
	op1 = op1_v;
	fmt = fmt_v;
	funct = funct_v;
	x1 = a;
	x2 = b;
endtask

task automatic compare_y(input fp32_t expected, input fp32_t actual);
	if (actual !== expected) begin
		$display("Error: y expected %h got %h", expected, actual);
		$display("Test failed");
		$fatal(1);
	end
endtask

task automatic compare_exception(input fpu_exc_t expected, input fpu_exc_t actual);
	if (actual !== expected) begin
		$display("Error: exception expected %h got %h", expected, actual);
		$display("Test failed");
		$fatal(1);
	end
endtask

// one instruction with its result read two edges after capture
task automatic check_instr(input logic [5:0] op1_v, input logic [4:0] fmt_v,
		input logic [5:0] funct_v, input fp32_t a, input fp32_t b,
		input fp32_t y_exp, input fpu_exc_t exc_exp);
	apply_instr(op1_v, fmt_v, funct_v, a, b);
	repeat (2) @(posedge clk);
	#1;
	compare_y(y_exp, y);
	compare_exception(exc_exp, exception);
endtask

task automatic expect_single_fmt(input logic [5:0] funct_v, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] y_exp, input logic [3:0] exc_exp);
	check_instr(`FPU_OP_COP1, `FPU_FMT_S, funct_v, a, b, y_exp, exc_exp);
endtask

task automatic arith_on_integers(input logic [5:0] fn);
	int va;
	int vb;
	fp32_t ye;
	fpu_exc_t ee;
	for (int i = 0; i < num_arith; i++) begin
		va = random_int();
		vb = random_int();
		if (i % 5 == 0) begin	// cancellation for add and sub and a zero factor for mul
			vb = (fn == `FPU_FN_SUB) ? va : -va;
			va = (fn == `FPU_FN_MUL) ? 0 : va;
		end
		reference_model(fn, va, vb, ye, ee);
		expect_single_fmt(fn, int_to_fp32(va), int_to_fp32(vb), ye, ee);
	end
endtask

task automatic overflow_cases();
	expect_single_fmt(`FPU_FN_ADD, 32'h7f00_0000, 32'h7f00_0000, 32'h7f80_0000, 4'b0001);
	expect_single_fmt(`FPU_FN_MUL, 32'h7f00_0000, 32'h4000_0000, 32'h7f80_0000, 4'b0001);
	// max finite minus 2^127 is (2 - 2^-22) * 2^126
	expect_single_fmt(`FPU_FN_ADD, 32'h7f7f_ffff, 32'hff00_0000, 32'h7eff_fffe, 4'b0000);
	expect_single_fmt(`FPU_FN_SUB, 32'h7f00_0000, 32'h7f00_0000, 32'h0000_0000, 4'b0000);
endtask

task automatic special_value_cases();
	expect_single_fmt(`FPU_FN_SUB, 32'h7f80_0000, 32'h7f80_0000, 32'hffc0_0000, 4'b0000);
	expect_single_fmt(`FPU_FN_SUB, 32'hff80_0000, 32'hff80_0000, 32'hffc0_0000, 4'b0000);
	expect_single_fmt(`FPU_FN_MUL, 32'h7f80_0000, 32'h0000_0000, 32'hffc0_0000, 4'b0000);
	expect_single_fmt(`FPU_FN_MUL, 32'h8000_0000, 32'hff80_0000, 32'hffc0_0000, 4'b0000);
	// signalling nan comes back with bit 22 set
	expect_single_fmt(`FPU_FN_ADD, 32'h7f80_0001, 32'h3f80_0000, 32'h7fc0_0001, 4'b0000);
	expect_single_fmt(`FPU_FN_MUL, 32'h3f80_0000, 32'hffa0_0000, 32'hffe0_0000, 4'b0000);
	expect_single_fmt(`FPU_FN_ADD, 32'hff80_0000, 32'h4200_0000, 32'hff80_0000, 4'b0000);
	expect_single_fmt(`FPU_FN_SUB, 32'h4040_0000, 32'hff80_0000, 32'h7f80_0000, 4'b0000);
endtask

task automatic abs_neg_random();
	fp32_t v;
	for (int i = 0; i < num_absneg; i++) begin
		v = next_random();
		expect_single_fmt(`FPU_FN_ABS, v, next_random(), {1'b0, v[30:0]}, 4'b0000);
		expect_single_fmt(`FPU_FN_NEG, v, next_random(), {~v[31], v[30:0]}, 4'b0000);
	end
endtask

task automatic invalid_encodings();
	check_instr(`FPU_OP_COP1, `FPU_FMT_S, 6'd3, 32'h3f80_0000, 32'h4000_0000, '0, 4'b1000);
	check_instr(`FPU_OP_COP1, `FPU_FMT_S, 6'd15, 32'h3fc0_0000, '0, '0, 4'b1000);	// floor.w
	check_instr(6'b000000, `FPU_FMT_S, `FPU_FN_ADD, 32'h3f80_0000, 32'h3f80_0000, '0, 4'b1000);
	check_instr(`FPU_OP_COP1, 5'b10001, `FPU_FN_ADD, 32'h3f80_0000, '0, '0, 4'b1000);
endtask

task automatic pipeline_burst();
	logic [5:0] fn_list [6];
	fp32_t a [burst_len];
	fp32_t b [burst_len];
	fp32_t ye [burst_len];
	fpu_exc_t ee [burst_len];
	int va;
	int vb;
	fn_list = '{`FPU_FN_ADD, `FPU_FN_SUB, `FPU_FN_MUL, `FPU_FN_ABS, `FPU_FN_NEG, 6'd3};
	for (int i = 0; i < burst_len; i++) begin
		va = random_int();
		vb = random_int();
		a[i] = int_to_fp32(va);
		b[i] = int_to_fp32(vb);
		reference_model(fn_list[i % 6], va, vb, ye[i], ee[i]);
	end
	// new instruction every cycle
	for (int c = 0; c < burst_len + 2; c++) begin
		if (c < burst_len) begin
			apply_instr(`FPU_OP_COP1, `FPU_FMT_S, fn_list[c % 6], a[c], b[c]);
		end else begin
			@(posedge clk);
			#1;
		end
		if (c >= 2) begin	// issued two edges ago
			compare_y(ye[c - 2], y);
			compare_exception(ee[c - 2], exception);
		end
	end
endtask

/* tb/tb_fpu.sv */
`default_nettype none
`include "fpu_settings.svh"

module tb_fpu;
	import fpu_pkg::*;

	localparam int num_arith = 30;	// per add, sub and mul
	localparam int num_absneg = 10;
	localparam int num_directed = 16;
	localparam int burst_len = 12;
	// a single check spans 3 rising edges
	localparam int drive_cycles = 8 + burst_len + 2 +
		3 * (3 * num_arith + 2 * num_absneg + num_directed);
	localparam int cycle_limit = 2 * drive_cycles;

	logic clk;
	logic rst_n;
	logic [5:0] op1;
	logic [4:0] fmt;
	logic [5:0] funct;
	fp32_t x1;
	fp32_t x2;
	fp32_t y;
	fpu_exc_t exception;
	logic [31:0] lcg_state;
	int cycles = 0;

	fpu_top i_dut (.*);

	`include "tb_fpu_tasks.svh"

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("Test failed");
			$fatal(1);
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		op1 = '0;
		fmt = '0;
		funct = '0;
		x1 = '0;
		x2 = '0;
		lcg_state = 32'hb705_3e35;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		compare_y('0, y);	// still the reset values
		compare_exception('0, exception);
		arith_on_integers(`FPU_FN_ADD);
		arith_on_integers(`FPU_FN_SUB);
		arith_on_integers(`FPU_FN_MUL);
		overflow_cases();
		special_value_cases();
		abs_neg_random();
		invalid_encodings();
		pipeline_burst();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
